/* all.f */
design/interconnect_pkg.sv
design/mem_request_decode.sv
design/console_rx_fifo.sv
design/load_response.sv
design/tohost_unit.sv
design/rvsoc_interconnect.sv
testbench/tb_interconnect.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the interconnect testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_interconnect \
    -o tb_sim > build.log 2>&1
status=$?
cat build.log
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation run returned an error"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
    echo "No result line in the log"
    exit 1
fi
exit 0

/* testbench/tb_interconnect.sv */
/*
 * Testbench for the memory-side interconnect
 * Drives DRAM loads, device routing, DRAM busy, console FIFO traffic and
 * tohost commands; a reference model and concurrent assertions check the DUT
 */
`timescale 1ns/1ps
`default_nettype none

module tb_interconnect;

    localparam int RESET_CYCLES  = 16;
    localparam int LOAD_CYCLES   = 120;
    localparam int ROUTE_CYCLES  = 20;
    localparam int BUSY_CYCLES   = 16;
    localparam int CONS_CYCLES   = 80;
    localparam int TOHOST_CYCLES = 16;
    localparam int MARGIN_CYCLES = 100;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + LOAD_CYCLES + ROUTE_CYCLES +
                                   BUSY_CYCLES + CONS_CYCLES + TOHOST_CYCLES + MARGIN_CYCLES;

    logic                       CLK;
    logic                       rst_n;
    interconnect_pkg::mem_req_t cpu_req;
    logic                       dram_busy;
    logic [127:0]               dram_rdata;
    logic [31:0]                plic_rdata;
    logic [31:0]                clint_rdata;
    logic                       rx_valid;
    logic [7:0]                 rx_data;
    logic                       dram_rd_en;
    logic                       dram_wr_en;
    logic [31:0]                dram_addr;
    logic [31:0]                dram_wdata;
    logic [2:0]                 dram_ctrl;
    logic                       plic_we;
    logic                       plic_re;
    logic                       clint_we;
    logic [31:0]                data_rdata;
    logic                       rdata_valid;
    logic                       proc_busy;
    logic [4:0]                 cons_count;
    logic                       uart_we;
    logic [7:0]                 uart_data;
    logic                       finish;

    // Reference model state
    logic [127:0] lines [16];
    logic [7:0]   cons_model [$];
    logic [4:0]   exp_count;
    logic         exp_valid;
    logic [31:0]  exp_data;
    logic         exp_uart_we;
    logic [7:0]   exp_uart_ch;
    logic         exp_finish;
    logic [3:0]   dev;
    integer       seed;
    int           errors;
    int           tests_run;

    rvsoc_interconnect i_rvsoc_interconnect (
        .CLK(CLK), .rst_n(rst_n), .cpu_req(cpu_req), .dram_busy(dram_busy),
        .dram_rdata(dram_rdata), .plic_rdata(plic_rdata), .clint_rdata(clint_rdata),
        .rx_valid(rx_valid), .rx_data(rx_data), .dram_rd_en(dram_rd_en),
        .dram_wr_en(dram_wr_en), .dram_addr(dram_addr), .dram_wdata(dram_wdata),
        .dram_ctrl(dram_ctrl), .plic_we(plic_we), .plic_re(plic_re), .clint_we(clint_we),
        .data_rdata(data_rdata), .rdata_valid(rdata_valid), .proc_busy(proc_busy),
        .cons_count(cons_count), .uart_we(uart_we), .uart_data(uart_data), .finish(finish)
    );

    always #2 CLK = ~CLK;

    assign dev = cpu_req.addr[31:28];

    // Byte-wise extraction of a load from a 16-byte line
    function automatic logic [31:0] load_expect(input logic [127:0] line,
                                                input logic [3:0] off, input logic [2:0] ctrl);
        logic [7:0] b [4];
        int         pos;
        for (int i = 0; i < 4; i++) begin
            pos = int'(off) + i;
            b[i] = (pos < 16) ? line[pos*8 +: 8] : 8'h00;
        end
        case (ctrl)
            3'd0:    return {{24{b[0][7]}}, b[0]};
            3'd1:    return {{16{b[1][7]}}, b[1], b[0]};
            3'd4:    return {24'h0, b[0]};
            3'd5:    return {16'h0, b[1], b[0]};
            default: return {b[3], b[2], b[1], b[0]};
        endcase
    endfunction

    // DRAM model, line addressed in cycle n is presented in cycle n+1
    always @(posedge CLK) begin
        dram_rdata <= lines[cpu_req.addr[7:4]];
    end

    always @(posedge CLK or negedge rst_n) begin : ref_model
        logic rd_ok;
        logic mbox_wr;
        if (!rst_n) begin
            exp_valid   <= 1'b0;
            exp_data    <= '0;
            exp_uart_we <= 1'b0;
            exp_uart_ch <= '0;
            exp_finish  <= 1'b0;
            exp_count   <= '0;
            cons_model.delete();
        end else begin
            rd_ok   = cpu_req.re && !dram_busy;
            mbox_wr = cpu_req.we && (cpu_req.addr == 32'h8000_1000);
            exp_valid <= rd_ok;
            if (rd_ok) begin
                if (dev == 4'h0 || dev == 4'h8)
                    exp_data <= load_expect(lines[cpu_req.addr[7:4]], cpu_req.addr[3:0],
                                            cpu_req.ctrl);
                else if (dev == 4'h5)
                    exp_data <= plic_rdata;
                else if (dev == 4'h6)
                    exp_data <= clint_rdata;
                else if (dev == 4'h4)
                    exp_data <= (cons_model.size() != 0) ? {23'h0, 1'b1, cons_model[0]} : '0;
                else
                    exp_data <= '0;
            end
            // Push is judged on the fill level before any pop
            if (rd_ok && dev == 4'h4 && cons_model.size() != 0) begin
                if (rx_valid && cons_model.size() < 16)
                    cons_model.push_back(rx_data);
                void'(cons_model.pop_front());
            end else if (rx_valid && cons_model.size() < 16) begin
                cons_model.push_back(rx_data);
            end
            exp_count <= 5'(cons_model.size());
            if (!exp_finish) begin
                exp_uart_we <= mbox_wr && (cpu_req.wdata[31:16] == 16'h0101);
                exp_uart_ch <= cpu_req.wdata[7:0];
                exp_finish  <= mbox_wr && (cpu_req.wdata[31:16] == 16'h0002);
            end
        end
    end

    a_valid: assert property (@(posedge CLK) disable iff (!rst_n) rdata_valid == exp_valid)
        else begin
            errors++;
            $display("FAIL rdata_valid: got %h expected %h", $sampled(rdata_valid),
                     $sampled(exp_valid));
        end

    a_data: assert property (@(posedge CLK) disable iff (!rst_n)
        exp_valid |-> data_rdata == exp_data)
        else begin
            errors++;
            $display("FAIL data_rdata: got %h expected %h", $sampled(data_rdata),
                     $sampled(exp_data));
        end

    a_plic: assert property (@(posedge CLK) disable iff (!rst_n)
        !dram_busy && dev == 4'h5 |->
            plic_re == cpu_req.re && plic_we == cpu_req.we && !dram_rd_en && !dram_wr_en)
        else begin
            errors++;
            $display(
                "FAIL plic_re/plic_we/dram_rd_en/dram_wr_en: got %h/%h/%h/%h expected %h/%h/0/0",
                $sampled(plic_re), $sampled(plic_we), $sampled(dram_rd_en),
                $sampled(dram_wr_en), $sampled(cpu_req.re), $sampled(cpu_req.we));
        end

    a_clint: assert property (@(posedge CLK) disable iff (!rst_n)
        !dram_busy && dev == 4'h6 |-> clint_we == cpu_req.we && !dram_rd_en && !dram_wr_en)
        else begin
            errors++;
            $display("FAIL clint_we/dram_rd_en/dram_wr_en: got %h/%h/%h expected %h/0/0",
                     $sampled(clint_we), $sampled(dram_rd_en), $sampled(dram_wr_en),
                     $sampled(cpu_req.we));
        end

    a_dram_en: assert property (@(posedge CLK) disable iff (!rst_n)
        !dram_busy && (dev == 4'h0 || dev == 4'h8) |->
            dram_rd_en == cpu_req.re && dram_wr_en == cpu_req.we)
        else begin
            errors++;
            $display("FAIL dram_rd_en/dram_wr_en: got %h/%h expected %h/%h",
                     $sampled(dram_rd_en), $sampled(dram_wr_en), $sampled(cpu_req.re),
                     $sampled(cpu_req.we));
        end

    a_dram_addr: assert property (@(posedge CLK) disable iff (!rst_n)
        dram_addr == (cpu_req.addr & 32'h07ff_ffff))
        else begin
            errors++;
            $display("FAIL dram_addr: got %h expected %h", $sampled(dram_addr),
                     $sampled(cpu_req.addr) & 32'h07ff_ffff);
        end

    a_dram_data: assert property (@(posedge CLK) disable iff (!rst_n)
        !dram_busy && (dev == 4'h0 || dev == 4'h8) && (cpu_req.re || cpu_req.we) |->
            dram_ctrl == cpu_req.ctrl && (!cpu_req.we || dram_wdata == cpu_req.wdata))
        else begin
            errors++;
            $display("FAIL dram_wdata/dram_ctrl: got %h/%h expected %h/%h",
                     $sampled(dram_wdata), $sampled(dram_ctrl), $sampled(cpu_req.wdata),
                     $sampled(cpu_req.ctrl));
        end

    a_busy: assert property (@(posedge CLK) disable iff (!rst_n)
        dram_busy |-> !dram_rd_en && !dram_wr_en)
        else begin
            errors++;
            $display("FAIL dram_rd_en/dram_wr_en while busy: got %h/%h expected 0/0",
                     $sampled(dram_rd_en), $sampled(dram_wr_en));
        end

    a_proc_busy: assert property (@(posedge CLK) disable iff (!rst_n) proc_busy == dram_busy)
        else begin
            errors++;
            $display("FAIL proc_busy: got %h expected %h", $sampled(proc_busy),
                     $sampled(dram_busy));
        end

    a_count: assert property (@(posedge CLK) disable iff (!rst_n) cons_count == exp_count)
        else begin
            errors++;
            $display("FAIL cons_count: got %h expected %h", $sampled(cons_count),
                     $sampled(exp_count));
        end

    a_uart: assert property (@(posedge CLK) disable iff (!rst_n)
        uart_we == exp_uart_we && (exp_uart_we -> uart_data == exp_uart_ch))
        else begin
            errors++;
            $display("FAIL uart_we/uart_data: got %h/%h expected %h/%h", $sampled(uart_we),
                     $sampled(uart_data), $sampled(exp_uart_we), $sampled(exp_uart_ch));
        end

    a_finish: assert property (@(posedge CLK) disable iff (!rst_n) finish == exp_finish)
        else begin
            errors++;
            $display("FAIL finish: got %h expected %h", $sampled(finish),
                     $sampled(exp_finish));
        end

    task automatic drive_access(input logic [31:0] addr, input logic we, input logic re,
                                input logic [2:0] ctrl, input logic [31:0] wdata);
        @(posedge CLK);
        cpu_req.addr  <= addr;
        cpu_req.we    <= we;
        cpu_req.re    <= re;
        cpu_req.ctrl  <= ctrl;
        cpu_req.wdata <= wdata;
        rx_valid      <= 1'b0;
    endtask

    task automatic drive_idle();
        @(posedge CLK);
        cpu_req.we <= 1'b0;
        cpu_req.re <= 1'b0;
        rx_valid   <= 1'b0;
    endtask

    task automatic push_byte(input logic [7:0] b);
        @(posedge CLK);
        cpu_req.we <= 1'b0;
        cpu_req.re <= 1'b0;
        rx_valid   <= 1'b1;
        rx_data    <= b;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        $display("Test %s finished, %0d failures so far", name, errors);
    endtask

    initial begin
        #(TOTAL_CYCLES * 4);
        $display("Watchdog timeout, the run did not complete in time");
        $display("Simulation failed");
        $finish;
    end

    initial begin : stimulus
        logic [2:0]  types [5];
        logic [31:0] r;
        types = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        seed = 32'h538c_305d;
        errors = 0;
        tests_run = 0;
        CLK = 1'b0;
        rst_n = 1'b0;
        cpu_req = '0;
        dram_busy = 1'b0;
        dram_rdata = '0;
        plic_rdata = '0;
        clint_rdata = '0;
        rx_valid = 1'b0;
        rx_data = '0;
        for (int i = 0; i < 16; i++)
            lines[i] = {$random(seed), $random(seed), $random(seed), $random(seed)};
        repeat (RESET_CYCLES) @(posedge CLK);
        rst_n <= 1'b1;

        // Random loads from both DRAM windows, mostly back to back
        for (int i = 0; i < 80; i++) begin
            r = $random(seed);
            drive_access({r[31] ? 4'h8 : 4'h0, r[27:0]}, 1'b0, 1'b1,
                         types[($random(seed) & 32'h7fff_ffff) % 5], '0);
            if (r[30:29] == 2'b00)
                drive_idle();
        end
        drive_idle();
        report_test("dram_loads");

        plic_rdata  <= $random(seed);
        clint_rdata <= $random(seed);
        drive_access({4'h5, 28'h000_0010}, 1'b0, 1'b1, 3'd2, '0);
        drive_access({4'h5, 28'h000_0020}, 1'b1, 1'b0, 3'd2, 32'h1234_5678);
        drive_access({4'h6, 28'h000_4000}, 1'b0, 1'b1, 3'd2, '0);
        drive_access({4'h6, 28'h000_4008}, 1'b1, 1'b0, 3'd2, 32'hcafe_0001);
        drive_access({4'h8, 28'h800_0040}, 1'b1, 1'b0, 3'd2, 32'h0bad_f00d);
        drive_access({4'h0, 28'h800_0050}, 1'b1, 1'b0, 3'd2, 32'h0000_beef);
        drive_access({4'h1, 28'h000_0000}, 1'b0, 1'b1, 3'd2, '0);
        drive_idle();
        report_test("routing");

        dram_busy <= 1'b1;
        drive_access({4'h8, 28'h000_0030}, 1'b0, 1'b1, 3'd2, '0);
        drive_access({4'h0, 28'h000_0060}, 1'b1, 1'b0, 3'd2, 32'h5555_aaaa);
        drive_access({4'h5, 28'h000_0010}, 1'b0, 1'b1, 3'd2, '0);
        @(posedge CLK);
        dram_busy <= 1'b0;
        drive_access({4'h8, 28'h000_0030}, 1'b0, 1'b1, 3'd2, '0);
        drive_idle();
        report_test("busy");

        for (int i = 0; i < 5; i++)
            push_byte(8'h41 + 8'(i));
        for (int i = 0; i < 6; i++)
            drive_access({4'h4, 28'h0}, 1'b0, 1'b1, 3'd2, '0);
        for (int i = 0; i < 20; i++)
            push_byte($random(seed));
        drive_idle();
        for (int i = 0; i < 17; i++)
            drive_access({4'h4, 28'h0}, 1'b0, 1'b1, 3'd2, '0);
        drive_idle();
        report_test("console_fifo");

        drive_access(32'h8000_1000, 1'b1, 1'b0, 3'd2, 32'h0101_005a);
        drive_idle();
        drive_idle();
        drive_access(32'h8000_1000, 1'b1, 1'b0, 3'd2, 32'h0002_0000);
        repeat (4) drive_idle();
        report_test("tohost");

        repeat (3) @(posedge CLK);
        $display("Tests run: %0d, failed checks: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/rvsoc_interconnect.sv */
/*
 * Memory-side interconnect top
 * Request decoder, console receive FIFO, load response stage and tohost
 * mailbox for a machine-mode RISC-V core
 */
`timescale 1ns/1ps
`default_nettype none

module rvsoc_interconnect (
    input  wire                                     CLK,
    input  wire                                     rst_n,
    input  interconnect_pkg::mem_req_t              cpu_req,
    input  wire                                     dram_busy,
    input  wire  [127:0]                            dram_rdata,
    input  wire  [31:0]                             plic_rdata,
    input  wire  [31:0]                             clint_rdata,
    input  wire                                     rx_valid,
    input  wire  [7:0]                              rx_data,
    output logic                                    dram_rd_en,
    output logic                                    dram_wr_en,
    output logic [31:0]                             dram_addr,
    output logic [31:0]                             dram_wdata,
    output logic [2:0]                              dram_ctrl,
    output logic                                    plic_we,
    output logic                                    plic_re,
    output logic                                    clint_we,
    output logic [31:0]                             data_rdata,
    output logic                                    rdata_valid,
    output logic                                    proc_busy,
    output logic [interconnect_pkg::CONS_CNT_W-1:0] cons_count,
    output logic                                    uart_we,
    output logic [7:0]                              uart_data,
    output logic                                    finish
);

    interconnect_pkg::rd_ctx_t rd_ctx;
    logic                      rd_pending;
    logic                      cons_pop;
    logic [8:0]                cons_head;
    logic [8:0]                cons_head_q;

    // Only DRAM can stall the core here
    assign proc_busy = dram_busy;

    mem_request_decode i_mem_request_decode (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .cpu_req      (cpu_req),
        .dram_busy    (dram_busy),
        .dram_rd_en   (dram_rd_en),
        .dram_wr_en   (dram_wr_en),
        .dram_addr    (dram_addr),
        .dram_wdata   (dram_wdata),
        .dram_ctrl    (dram_ctrl),
        .plic_we      (plic_we),
        .plic_re      (plic_re),
        .clint_we     (clint_we),
        .cons_pop     (cons_pop),
        .rd_ctx       (rd_ctx),
        .rd_pending   (rd_pending),
        .cons_head_in (cons_head),
        .cons_head_q  (cons_head_q)
    );

    console_rx_fifo i_console_rx_fifo (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .pop      (cons_pop),
        .head     (cons_head),
        .count    (cons_count)
    );

    load_response i_load_response (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .rd_ctx      (rd_ctx),
        .rd_pending  (rd_pending),
        .dram_rdata  (dram_rdata),
        .plic_rdata  (plic_rdata),
        .clint_rdata (clint_rdata),
        .cons_head   (cons_head_q),
        .data_rdata  (data_rdata),
        .rdata_valid (rdata_valid)
    );

    tohost_unit i_tohost_unit (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .cpu_req   (cpu_req),
        .uart_we   (uart_we),
        .uart_data (uart_data),
        .finish    (finish)
    );

endmodule

`default_nettype wire

/* design/tohost_unit.sv */
/*
 * Tohost mailbox
 * Captures CPU writes to the mailbox address. A print-char word puts
 * one character out and clears the mailbox; power-off latches finish
 */
`timescale 1ns/1ps
`default_nettype none

module tohost_unit (
    input  wire                        CLK,
    input  wire                        rst_n,
    input  interconnect_pkg::mem_req_t cpu_req,
    output logic                       uart_we,
    output logic [7:0]                 uart_data,
    output logic                       finish
);

    interconnect_pkg::tohost_word_u mbox;
    logic                           finish_q;
    logic                           is_print;
    logic                           is_off;
    logic                           mbox_wr;

    assign is_print = (mbox.fields.cmd == interconnect_pkg::CMD_PRINT_CHAR);
    assign is_off   = (mbox.fields.cmd == interconnect_pkg::CMD_POWER_OFF);
    assign mbox_wr  = cpu_req.we && (cpu_req.addr == interconnect_pkg::TOHOST_ADDR);

    // Character goes out the cycle after the mailbox is loaded
    assign uart_we   = is_print;
    assign uart_data = mbox.fields.ch;
    assign finish    = finish_q || is_off;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            mbox.raw <= 32'h0;
            finish_q <= 1'b0;
        end else if (is_off || finish_q) begin
            // Frozen once powered off
            finish_q <= 1'b1;
        end else if (mbox_wr) begin
            mbox.raw <= cpu_req.wdata;
        end else if (is_print) begin
            mbox.raw <= 32'h0;
        end
    end

    a_no_char_after_finish: assert property (
        @(posedge CLK) disable iff (!rst_n)
        finish_q |-> !uart_we
    );

endmodule

`default_nettype wire

/* design/load_response.sv */
/*
 * Load response stage
 * One cycle after a read, picks the returning device by the captured
 * context. DRAM lines are shifted to the byte offset and extended by
 * the load type; unmapped devices read zero
 */
`timescale 1ns/1ps
`default_nettype none

module load_response (
    input  wire                       CLK,
    input  wire                       rst_n,
    input  interconnect_pkg::rd_ctx_t rd_ctx,
    input  wire                       rd_pending,
    input  wire  [127:0]              dram_rdata,
    input  wire  [31:0]               plic_rdata,
    input  wire  [31:0]               clint_rdata,
    input  wire  [8:0]                cons_head,
    output logic [31:0]               data_rdata,
    output logic                      rdata_valid
);

    logic [127:0] line_shift;
    logic [31:0]  word;
    logic         sext;
    logic [31:0]  dram_word;

    // Line aligned so the addressed byte lands at bit 0
    assign line_shift = dram_rdata >> {rd_ctx.offset, 3'b000};
    assign word       = line_shift[31:0];
    assign sext       = !rd_ctx.ctrl[2];

    always_comb begin
        case (rd_ctx.ctrl)
            interconnect_pkg::LD_BYTE,
            interconnect_pkg::LD_BYTE_U: begin
                dram_word = {{24{word[7] & sext}}, word[7:0]};
            end
            interconnect_pkg::LD_HALF,
            interconnect_pkg::LD_HALF_U: begin
                dram_word = {{16{word[15] & sext}}, word[15:0]};
            end
            interconnect_pkg::LD_WORD: begin
                dram_word = word;
            end
            default: begin
                dram_word = word;
            end
        endcase
    end

    // Return mux
    always_comb begin
        if (rd_ctx.is_dram) begin
            data_rdata = dram_word;
        end else begin
            case (rd_ctx.dev)
                interconnect_pkg::DEV_PLIC:    data_rdata = plic_rdata;
                interconnect_pkg::DEV_CLINT:   data_rdata = clint_rdata;
                interconnect_pkg::DEV_CONSOLE: data_rdata = {23'h0, cons_head};
                default:                       data_rdata = 32'h0;
            endcase
        end
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= rd_pending;
        end
    end

endmodule

`default_nettype wire

/* design/console_rx_fifo.sv */
/*
 * Console receive FIFO
 * Circular buffer of received console bytes. New bytes are dropped when
 * full, a pop of an empty buffer is ignored. Head carries a valid bit
 */
`timescale 1ns/1ps
`default_nettype none

module console_rx_fifo (
    input  wire                                     CLK,
    input  wire                                     rst_n,
    input  wire                                     rx_valid,
    input  wire  [7:0]                              rx_data,
    input  wire                                     pop,
    output logic [8:0]                              head,
    output logic [interconnect_pkg::CONS_CNT_W-1:0] count
);

    localparam logic [interconnect_pkg::CONS_CNT_W-1:0] FULL_CNT =
        interconnect_pkg::CONS_CNT_W'(interconnect_pkg::CONS_DEPTH);

    logic [7:0]                              mem [interconnect_pkg::CONS_DEPTH];
    logic [interconnect_pkg::CONS_PTR_W-1:0] rd_ptr;
    logic [interconnect_pkg::CONS_PTR_W-1:0] wr_ptr;
    logic                                    empty;
    logic                                    push_ok;
    logic                                    pop_ok;

    assign empty   = (count == '0);
    assign push_ok = rx_valid && (count != FULL_CNT);
    assign pop_ok  = pop && !empty;

    // Empty reads as zero
    assign head = empty ? 9'h000 : {1'b1, mem[rd_ptr]};

    always_ff @(posedge CLK) begin
        if (push_ok) begin
            mem[wr_ptr] <= rx_data;
        end
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop together leave the count alone
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_max: assert property (
        @(posedge CLK) disable iff (!rst_n)
        count <= FULL_CNT
    );

endmodule

`default_nettype wire

/* design/mem_request_decode.sv */
/*
 * Memory request decoder
 * Routes each CPU data access by address bits 31:28, drives the DRAM
 * enables held off by busy, raises the PLIC, CLINT and console strobes,
 * and captures the read context and console head for the return path
 */
`timescale 1ns/1ps
`default_nettype none

module mem_request_decode (
    input  wire                        CLK,
    input  wire                        rst_n,
    input  interconnect_pkg::mem_req_t cpu_req,
    input  wire logic                  dram_busy,
    output logic                       dram_rd_en,
    output logic                       dram_wr_en,
    output logic [31:0]                dram_addr,
    output logic [31:0]                dram_wdata,
    output logic [2:0]                 dram_ctrl,
    output logic                       plic_we,
    output logic                       plic_re,
    output logic                       clint_we,
    output logic                       cons_pop,
    output interconnect_pkg::rd_ctx_t  rd_ctx,
    output logic                       rd_pending,
    input  wire  [8:0]                 cons_head_in,
    output logic [8:0]                 cons_head_q
);

    logic [3:0] dev;
    logic       is_dram;
    logic       accept;
    logic       rd_acc;
    logic       wr_acc;

    assign dev     = cpu_req.addr[31:28];
    assign is_dram = (dev == interconnect_pkg::DEV_DRAM_LO) ||
                     (dev == interconnect_pkg::DEV_DRAM_HI);

    // Nothing is accepted while DRAM is busy, the CPU holds the access
    assign accept = !dram_busy;
    assign rd_acc = cpu_req.re && accept;
    assign wr_acc = cpu_req.we && accept;

    // DRAM side
    assign dram_rd_en = rd_acc && is_dram;
    assign dram_wr_en = wr_acc && is_dram;
    assign dram_addr  = cpu_req.addr & interconnect_pkg::OFFSET_MASK;
    assign dram_wdata = cpu_req.wdata;
    assign dram_ctrl  = cpu_req.ctrl;

    // Device strobes, same cycle as the request
    assign plic_we  = wr_acc && (dev == interconnect_pkg::DEV_PLIC);
    assign plic_re  = rd_acc && (dev == interconnect_pkg::DEV_PLIC);
    assign clint_we = wr_acc && (dev == interconnect_pkg::DEV_CLINT);
    assign cons_pop = rd_acc && (dev == interconnect_pkg::DEV_CONSOLE);

    // Accepted read strobe, the consumer turns it into rdata_valid
    assign rd_pending = rd_acc;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            rd_ctx <= '0;
        end else if (rd_acc) begin
            rd_ctx.dev     <= dev;
            rd_ctx.offset  <= cpu_req.addr[3:0];
            rd_ctx.ctrl    <= cpu_req.ctrl;
            rd_ctx.is_dram <= is_dram;
        end
    end

    // Head as seen in the pop cycle, before the FIFO advances
    always_ff @(posedge CLK) begin
        if (cons_pop) begin
            cons_head_q <= cons_head_in;
        end
    end

    a_dram_en_excl: assert property (
        @(posedge CLK) disable iff (!rst_n)
        !(dram_rd_en && dram_wr_en) && !((dram_rd_en || dram_wr_en) && dram_busy)
    );

endmodule

`default_nettype wire

/* design/interconnect_pkg.sv */
/*
 * Interconnect package
 * Address map, tohost command codes, load types and console FIFO sizes
 * shared by the memory-side interconnect, plus the request, read context
 * and tohost mailbox types
 */
`default_nettype none

package interconnect_pkg;

    // Device field values, address bits 31:28
    localparam logic [3:0] DEV_DRAM_LO = 4'h0;
    localparam logic [3:0] DEV_DRAM_HI = 4'h8;
    localparam logic [3:0] DEV_CONSOLE = 4'h4;
    localparam logic [3:0] DEV_PLIC    = 4'h5;
    localparam logic [3:0] DEV_CLINT   = 4'h6;

    // Mailbox sits inside DRAM space
    localparam logic [31:0] TOHOST_ADDR = 32'h8000_1000;
    localparam logic [31:0] OFFSET_MASK = 32'h07ff_ffff;

    // Tohost commands, upper half of the mailbox word
    localparam logic [15:0] CMD_PRINT_CHAR = 16'h0101;
    localparam logic [15:0] CMD_POWER_OFF  = 16'h0002;

    // Load types as funct3, bit 2 set means unsigned
    localparam logic [2:0] LD_BYTE   = 3'd0;
    localparam logic [2:0] LD_HALF   = 3'd1;
    localparam logic [2:0] LD_WORD   = 3'd2;
    localparam logic [2:0] LD_BYTE_U = 3'd4;
    localparam logic [2:0] LD_HALF_U = 3'd5;

    // Console receive FIFO
    localparam int CONS_DEPTH = 16;
    localparam int CONS_PTR_W = 4;
    localparam int CONS_CNT_W = 5;

    // One CPU data access, we and re are single-cycle strobes
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        we;
        logic        re;
        logic [2:0]  ctrl;
    } mem_req_t;

    // Captured at each accepted read, used in the following cycle
    typedef struct packed {
        logic [3:0] dev;
        logic [3:0] offset;
        logic [2:0] ctrl;
        logic       is_dram;
    } rd_ctx_t;

    // Command view of the mailbox word
    typedef struct packed {
        logic [15:0] cmd;
        logic [7:0]  pad;
        logic [7:0]  ch;
    } tohost_fields_t;

    typedef union packed {
        logic [31:0]    raw;
        tohost_fields_t fields;
    } tohost_word_u;

endpackage

`default_nettype wire
